/* rtl/pipeCtrlPkg.sv */
// Pipeline control package
// ISA field types, opcode values and the control structs shared by the hazard logic
package pipeCtrlPkg;

  //////////////////////////////////////////////////
  // ISA field types
  //////////////////////////////////////////////////
  typedef logic [15:0] instrT;   // Op [15:12], rd [11:8], rs [7:4], rt [3:0]
  typedef logic [3:0]  regIdxT;  // One of sixteen registers, r0 reads as zero
  typedef logic [3:0]  opcodeT;  // Top nibble of the instruction word

  //////////////////////////////////////////////////
  // Opcode values
  //////////////////////////////////////////////////
  // ALU group
  localparam opcodeT ADD    = 4'h0;
  localparam opcodeT SUB    = 4'h1;
  localparam opcodeT XOR    = 4'h2;
  localparam opcodeT RED    = 4'h3;
  localparam opcodeT SLL    = 4'h4;
  localparam opcodeT SRA    = 4'h5;
  localparam opcodeT ROR    = 4'h6;
  localparam opcodeT PADDSB = 4'h7;
  // Memory and byte loads
  localparam opcodeT LW     = 4'h8;
  localparam opcodeT SW     = 4'h9;
  localparam opcodeT LLB    = 4'hA;
  localparam opcodeT LHB    = 4'hB;
  // Control flow
  localparam opcodeT B      = 4'hC;
  localparam opcodeT BR     = 4'hD;
  localparam opcodeT PCS    = 4'hE;
  localparam opcodeT HLT    = 4'hF;

  //////////////////////////////////////////////////
  // Control structs
  //////////////////////////////////////////////////
  // Everything the decode stage knows about its instruction
  typedef struct packed {
    regIdxT srcReg1;    // First register read, zero when unused
    regIdxT srcReg2;    // Second register read, zero when unused
    regIdxT rd;         // Destination register
    logic   regWrite;   // Writes rd at WB
    logic   memEnable;  // Touches data memory
    logic   memWrite;   // Store
    logic   zEn;        // Updates Z flag
    logic   nvEn;       // Updates N and V flags
    logic   branch;     // B or BR
    logic   br;         // Register-indirect branch
  } decodedT;

  // Fields carried through ID/EX and EX/MEM
  typedef struct packed {
    regIdxT rd;
    logic   regWrite;
    logic   memEnable;
    logic   memWrite;
    logic   zEn;
    logic   nvEn;
  } stageCtrlT;

  localparam stageCtrlT BUBBLE = '0;  // NOP in a stage register

  // Stall and flush strobes for PC and the four pipeline registers
  typedef struct packed {
    logic pcStall;
    logic ifIdStall;
    logic idExStall;
    logic exMemStall;
    logic memFlush;    // NOP into MEM/WB
    logic idFlush;     // NOP into ID/EX
    logic ifFlush;     // NOP into IF/ID
  } hazardCtrlT;

endpackage

/* rtl/instrDecoder.sv */
// Instruction decoder
// Splits the IF/ID word into register reads, destination and control bits
module instrDecoder import pipeCtrlPkg::*; (
  input  instrT   instr,    // Word sitting in IF/ID
  output decodedT decoded   // Fields seen by the control pipe and hazard unit
);

  //////////////////////////////////////////////////
  // Raw instruction fields
  //////////////////////////////////////////////////
  opcodeT op;
  regIdxT rdIdx;
  regIdxT rsIdx;
  regIdxT rtIdx;

  assign op    = instr[15:12];
  assign rdIdx = instr[11:8];
  assign rsIdx = instr[7:4];
  assign rtIdx = instr[3:0];

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////
  // Source fields stay zero unless the opcode really reads them,
  // since r0 never counts as a dependency
  always_comb begin
    decoded = '0;  // HLT and anything unlisted do nothing
    case (op)
      ADD, SUB, PADDSB: begin
        decoded.srcReg1  = rsIdx;
        decoded.srcReg2  = rtIdx;
        decoded.rd       = rdIdx;
        decoded.regWrite = 1'b1;
        decoded.zEn      = 1'b1;
        decoded.nvEn     = 1'b1;  // Arithmetic sets all three flags
      end
      XOR, RED, SLL, SRA, ROR: begin
        decoded.srcReg1  = rsIdx;
        decoded.srcReg2  = rtIdx;
        decoded.rd       = rdIdx;
        decoded.regWrite = 1'b1;
        decoded.zEn      = 1'b1;  // Logic and shifts only touch Z
      end
      LW: begin
        decoded.srcReg1   = rsIdx;  // Base address
        decoded.rd        = rdIdx;
        decoded.regWrite  = 1'b1;
        decoded.memEnable = 1'b1;
      end
      SW: begin
        decoded.srcReg1   = rsIdx;  // Base address
        decoded.srcReg2   = rdIdx;  // Store data lives in the rd field
        decoded.memEnable = 1'b1;
        decoded.memWrite  = 1'b1;
      end
      LLB, LHB: begin
        // Byte loads merge into the old value of rd
        decoded.srcReg1  = rdIdx;
        decoded.rd       = rdIdx;
        decoded.regWrite = 1'b1;
      end
      B: begin
        decoded.branch = 1'b1;  // Condition codes only
      end
      BR: begin
        decoded.srcReg1 = rsIdx;  // Target register
        decoded.branch  = 1'b1;
        decoded.br      = 1'b1;
      end
      PCS: begin
        decoded.rd       = rdIdx;  // Saves PC+2
        decoded.regWrite = 1'b1;
      end
      HLT: begin
        decoded = '0;
      end
      default: begin
        decoded = '0;
      end
    endcase
  end

endmodule

/* rtl/ctrlPipe.sv */
// Control pipeline
// ID/EX and EX/MEM control registers that track the instructions in flight
module ctrlPipe import pipeCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  decodedT    decoded,     // From the decoder this cycle
  input  hazardCtrlT hazardCtrl,  // Only the ID/EX and EX/MEM strobes are used
  output stageCtrlT  idEx,        // Instruction now in EX
  output stageCtrlT  exMem        // Instruction now in MEM
);

  //////////////////////////////////////////////////
  // Strobes and next-state values
  //////////////////////////////////////////////////
  logic      idExStall;
  logic      exMemStall;
  logic      idFlush;
  stageCtrlT nextIdEx;  // Decoded fields that travel down the pipe

  assign idExStall  = hazardCtrl.idExStall;
  assign exMemStall = hazardCtrl.exMemStall;
  assign idFlush    = hazardCtrl.idFlush;

  // Drop the decode-only fields
  assign nextIdEx = '{
    rd:        decoded.rd,
    regWrite:  decoded.regWrite,
    memEnable: decoded.memEnable,
    memWrite:  decoded.memWrite,
    zEn:       decoded.zEn,
    nvEn:      decoded.nvEn
  };

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////
  // Stall wins over flush so a frozen pipe keeps its contents
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= BUBBLE;
    end else if (idExStall) begin
      idEx <= idEx;            // Hold during a D-cache miss
    end else if (idFlush) begin
      idEx <= BUBBLE;          // Hazard in decode inserts a NOP
    end else begin
      idEx <= nextIdEx;
    end
  end

  //////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= BUBBLE;
    end else if (!exMemStall) begin
      exMem <= idEx;  // Advance a stage
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // The hazard unit ties idExStall to exMemStall, so a stall on
  // ID/EX must freeze both stage registers together
  stallHolds: assert property (
    @(posedge clk) disable iff (!rstN)
      idExStall |=> $stable({idEx, exMem})
  ) else $error("stage register changed while stalled");

endmodule

/* rtl/hazardUnit.sv */
// Hazard unit
// Detects load-to-use, B and BR hazards and forms the stall and flush strobes
module hazardUnit import pipeCtrlPkg::*; (
  input  logic       clk,         // Checks only
  input  logic       rstN,        // Checks only
  input  decodedT    decoded,     // Instruction in decode
  input  stageCtrlT  idEx,        // Instruction in EX
  input  stageCtrlT  exMem,       // Instruction in MEM
  input  logic       icacheMiss,
  input  logic       dcacheMiss,
  input  logic       updatePc,    // Taken branch redirects fetch
  output hazardCtrlT hazardCtrl
);

  //////////////////////////////////////////////////
  // Hazard terms
  //////////////////////////////////////////////////
  logic idExLoad;    // LW sitting in EX
  logic idExFlags;   // EX instruction updates condition codes
  logic exToIdBr;    // EX writes the BR target register
  logic memToIdBr;   // MEM writes the BR target register
  logic loadUseHaz;
  logic bHaz;
  logic brHaz;
  logic anyHaz;

  assign idExLoad  = idEx.memEnable & ~idEx.memWrite;
  assign idExFlags = idEx.zEn | idEx.nvEn;

  // SW data through srcReg2 is covered by MEM-to-MEM forwarding
  assign loadUseHaz = idExLoad && (idEx.rd != '0) &&
                      ((idEx.rd == decoded.srcReg1) ||
                       ((idEx.rd == decoded.srcReg2) && !decoded.memWrite));

  // Flags not settled yet
  assign bHaz = decoded.branch & idExFlags;

  assign exToIdBr  = idEx.regWrite && (idEx.rd != '0) && (idEx.rd == decoded.srcReg1);
  assign memToIdBr = exMem.regWrite && (exMem.rd != '0) && (exMem.rd == decoded.srcReg1);

  // BR needs both its flags and its target register
  assign brHaz = decoded.branch & decoded.br & (idExFlags | exToIdBr | memToIdBr);

  assign anyHaz = loadUseHaz | bHaz | brHaz;

  //////////////////////////////////////////////////
  // Stall and flush strobes
  //////////////////////////////////////////////////
  logic pcStall;
  logic ifIdStall;
  logic idExStall;
  logic exMemStall;
  logic memFlush;
  logic idFlush;
  logic ifFlush;

  assign exMemStall = dcacheMiss;               // D-cache miss freezes the back end
  assign idExStall  = exMemStall;
  assign memFlush   = dcacheMiss;               // NOP into MEM/WB while waiting
  assign ifIdStall  = exMemStall | anyHaz;      // Hold decode on a hazard
  assign pcStall    = icacheMiss | ifIdStall;

  // Bubble into EX only when EX itself is moving
  assign idFlush = anyHaz & ~idExStall;

  // Kill the fetched word unless decode is holding it
  assign ifFlush = (icacheMiss | updatePc) & ~ifIdStall;

  assign hazardCtrl = '{
    pcStall:    pcStall,
    ifIdStall:  ifIdStall,
    idExStall:  idExStall,
    exMemStall: exMemStall,
    memFlush:   memFlush,
    idFlush:    idFlush,
    ifFlush:    ifFlush
  };

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // A register is never asked to both hold and take a NOP
  noIdFlushOnStall: assert property (
    @(posedge clk) disable iff (!rstN)
      !(hazardCtrl.idFlush && hazardCtrl.idExStall)
  ) else $error("idFlush with idExStall");

  noIfFlushOnStall: assert property (
    @(posedge clk) disable iff (!rstN)
      !(hazardCtrl.ifFlush && hazardCtrl.ifIdStall)
  ) else $error("ifFlush with ifIdStall");

endmodule

/* rtl/pipeCtrlTop.sv */
// Pipeline hazard control top
// Decoder, control pipeline and hazard unit for the five-stage pipe
module pipeCtrlTop import pipeCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  instrT      instr,       // Word in IF/ID
  input  logic       icacheMiss,
  input  logic       dcacheMiss,
  input  logic       updatePc,
  output hazardCtrlT hazardCtrl   // Strobes for the current cycle
);

  //////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////
  decodedT   decoded;  // Combinational decode of instr
  stageCtrlT idEx;     // EX stage control
  stageCtrlT exMem;    // MEM stage control

  // Decode
  instrDecoder dec0 (
    .instr   (instr),
    .decoded (decoded)
  );

  // Execute, instructions in flight
  ctrlPipe pipe0 (
    .clk        (clk),
    .rstN       (rstN),
    .decoded    (decoded),
    .hazardCtrl (hazardCtrl),  // Fed back from haz0
    .idEx       (idEx),
    .exMem      (exMem)
  );

  // Result strobes
  hazardUnit haz0 (
    .clk        (clk),
    .rstN       (rstN),
    .decoded    (decoded),
    .idEx       (idEx),
    .exMem      (exMem),
    .icacheMiss (icacheMiss),
    .dcacheMiss (dcacheMiss),
    .updatePc   (updatePc),
    .hazardCtrl (hazardCtrl)
  );

endmodule

/* bench/pipeCtrlChecker.sv */
// Result checker for the pipeline hazard control testbench
// Compares the DUT strobes with the expected row at each rising edge
module pipeCtrlChecker import pipeCtrlPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  logic         checkEn,     // A table row is being applied
  input  logic [127:0] testName,    // Row name, ASCII, zero padded on the left
  input  hazardCtrlT   expected,    // Hand-derived strobes for this row
  input  hazardCtrlT   actual,      // DUT output
  output int           testCount,   // Rows compared so far
  output int           errorCount   // Rows that did not match
);

  //////////////////////////////////////////////////
  // Compare on the rising edge
  //////////////////////////////////////////////////
  // Inputs are driven on the falling edge, so both sides are settled here
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      testCount  <= 0;
      errorCount <= 0;
    end else if (checkEn) begin
      testCount <= testCount + 1;
      if (actual !== expected) begin
        errorCount <= errorCount + 1;
        $display("mismatch %0s expected %b actual %b", testName, expected, actual);
        showFields(actual);  // Field by field for quick debug
      end else begin
        $display("pass %0s hazardCtrl %b", testName, actual);
      end
    end
  end

  //////////////////////////////////////////////////
  // Field dump for a wrong row
  //////////////////////////////////////////////////
  task automatic showFields(input hazardCtrlT value);
    $display("  pcStall %b ifIdStall %b idExStall %b exMemStall %b",
             value.pcStall, value.ifIdStall, value.idExStall, value.exMemStall);
    $display("  memFlush %b idFlush %b ifFlush %b",
             value.memFlush, value.idFlush, value.ifFlush);
  endtask

endmodule

/* bench/pipeCtrlTb.sv */
// Testbench for the pipeline hazard control
// Applies a table of decode words and cache inputs, one row per cycle
module pipeCtrlTb import pipeCtrlPkg::*; ();

  //////////////////////////////////////////////////
  // Clock, reset and DUT signals
  //////////////////////////////////////////////////
  localparam int resetCycles = 5;

  // Strobe patterns {pc, ifId, idEx, exMem, memFlush, idFlush, ifFlush}
  localparam hazardCtrlT hzNone     = 7'b0000000;
  localparam hazardCtrlT hzStall    = 7'b1100010;  // Hazard in decode, bubble into EX
  localparam hazardCtrlT hzDmiss    = 7'b1111100;  // D-cache miss freezes everything
  localparam hazardCtrlT hzImiss    = 7'b1000001;  // Fetch waits, IF/ID gets a NOP
  localparam hazardCtrlT hzRedirect = 7'b0000001;  // Taken branch kills the fetched word

  logic       clk = 1'b0;
  logic       rstN;
  instrT      instr;
  logic       icacheMiss;
  logic       dcacheMiss;
  logic       updatePc;
  hazardCtrlT hazardCtrl;

  // Row under test, seen by the checker
  logic         checkEn;
  logic [127:0] testName;
  hazardCtrlT   expected;
  int           testCount;
  int           errorCount;

  int cycleCount = 0;
  int cycleLimit = 0;  // Set once the table is built

  typedef struct packed {
    logic [127:0] name;
    instrT        instr;
    logic         icacheMiss;
    logic         dcacheMiss;
    logic         updatePc;
    hazardCtrlT   expected;
  } rowT;

  rowT rows[$];

  always #10 clk = ~clk;  // Period 20

  pipeCtrlTop dut0 (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .icacheMiss (icacheMiss),
    .dcacheMiss (dcacheMiss),
    .updatePc   (updatePc),
    .hazardCtrl (hazardCtrl)
  );

  pipeCtrlChecker chk0 (
    .clk        (clk),
    .rstN       (rstN),
    .checkEn    (checkEn),
    .testName   (testName),
    .expected   (expected),
    .actual     (hazardCtrl),
    .testCount  (testCount),
    .errorCount (errorCount)
  );

  //////////////////////////////////////////////////
  // Table helpers
  //////////////////////////////////////////////////
  function automatic instrT encodeInstr(input opcodeT op, input regIdxT rd,
                                        input regIdxT rs, input regIdxT rt);
    return {op, rd, rs, rt};
  endfunction

  task automatic addRow(input logic [127:0] name, input instrT word, input logic iMiss,
                        input logic dMiss, input logic upd, input hazardCtrlT exp);
    rowT row;
    row = '{name: name, instr: word, icacheMiss: iMiss, dcacheMiss: dMiss,
            updatePc: upd, expected: exp};
    rows.push_back(row);
  endtask

  // Rows run back to back and each sees the pipe state left by the rows above
  task automatic fillTable();
    // Idle and r0
    addRow("idle_add",     encodeInstr(ADD, 4'h1, 4'h2, 4'h3), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("idle_xor",     encodeInstr(XOR, 4'h4, 4'h5, 4'h6), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("lw_r0",        encodeInstr(LW,  4'h0, 4'h2, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("read_r0",      encodeInstr(ADD, 4'h5, 4'h0, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    // Load to use
    addRow("lw_r3",        encodeInstr(LW,  4'h3, 4'h1, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("use_r3",       encodeInstr(ADD, 4'h4, 4'h3, 4'h2), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("use_r3_hold",  encodeInstr(ADD, 4'h4, 4'h3, 4'h2), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("lw_r3b",       encodeInstr(LW,  4'h3, 4'h1, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("sw_data_r3",   encodeInstr(SW,  4'h3, 4'h2, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("lw_r3c",       encodeInstr(LW,  4'h3, 4'h1, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("sw_base_r3",   encodeInstr(SW,  4'h5, 4'h3, 4'h0), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("sw_base_hold", encodeInstr(SW,  4'h5, 4'h3, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    // B and BR
    addRow("sub_flags",    encodeInstr(SUB, 4'h6, 4'h1, 4'h2), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("b_after_sub",  encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("b_hold",       encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("llb_r7",       encodeInstr(LLB, 4'h7, 4'h1, 4'h2), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("br_r7_ex",     encodeInstr(BR,  4'h0, 4'h7, 4'h0), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("br_r7_mem",    encodeInstr(BR,  4'h0, 4'h7, 4'h0), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("br_r7_go",     encodeInstr(BR,  4'h0, 4'h7, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("pcs_r8",       encodeInstr(PCS, 4'h8, 4'h0, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("br_unrelated", encodeInstr(BR,  4'h0, 4'h9, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    // D-cache miss, then a load-use that waits out the miss
    addRow("dmiss_idle",   encodeInstr(ADD, 4'h1, 4'h2, 4'h3), 1'b0, 1'b1, 1'b0, hzDmiss);
    addRow("dmiss_end",    encodeInstr(ADD, 4'h1, 4'h2, 4'h3), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("lw_r9",        encodeInstr(LW,  4'h9, 4'h2, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("use_r9_miss",  encodeInstr(ADD, 4'hA, 4'h1, 4'h9), 1'b0, 1'b1, 1'b0, hzDmiss);
    addRow("use_r9_miss2", encodeInstr(ADD, 4'hA, 4'h1, 4'h9), 1'b0, 1'b1, 1'b0, hzDmiss);
    addRow("use_r9_after", encodeInstr(ADD, 4'hA, 4'h1, 4'h9), 1'b0, 1'b0, 1'b0, hzStall);
    addRow("use_r9_go",    encodeInstr(ADD, 4'hA, 4'h1, 4'h9), 1'b0, 1'b0, 1'b0, hzNone);
    // Fetch side
    addRow("imiss",        encodeInstr(ADD, 4'hB, 4'h1, 4'h2), 1'b1, 1'b0, 1'b0, hzImiss);
    addRow("upd_pc",       encodeInstr(XOR, 4'hC, 4'h1, 4'h2), 1'b0, 1'b0, 1'b1, hzRedirect);
    addRow("lw_r4",        encodeInstr(LW,  4'h4, 4'h1, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
    addRow("imiss_haz",    encodeInstr(ADD, 4'h5, 4'h4, 4'h4), 1'b1, 1'b0, 1'b0, hzStall);
    addRow("imiss_hold",   encodeInstr(ADD, 4'h5, 4'h4, 4'h4), 1'b1, 1'b0, 1'b0, hzImiss);
    addRow("b_upd",        encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b0, 1'b0, 1'b1, hzStall);
    addRow("imiss_dmiss",  encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b1, 1'b1, 1'b0, hzDmiss);
    addRow("upd_dmiss",    encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b0, 1'b1, 1'b1, hzDmiss);
    addRow("b_go",         encodeInstr(B,   4'h0, 4'h0, 4'h4), 1'b0, 1'b0, 1'b1, hzRedirect);
    addRow("final_idle",   encodeInstr(HLT, 4'h0, 4'h0, 4'h0), 1'b0, 1'b0, 1'b0, hzNone);
  endtask

  task automatic applyRow(input rowT row);
    instr      = row.instr;
    icacheMiss = row.icacheMiss;
    dcacheMiss = row.dcacheMiss;
    updatePc   = row.updatePc;
    testName   = row.name;
    expected   = row.expected;
    checkEn    = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rstN       = 1'b0;
    instr      = encodeInstr(HLT, 4'h0, 4'h0, 4'h0);  // Decodes to nothing
    icacheMiss = 1'b0;
    dcacheMiss = 1'b0;
    updatePc   = 1'b0;
    checkEn    = 1'b0;
    testName   = '0;
    expected   = hzNone;
    fillTable();
    cycleLimit = rows.size() + 20;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    foreach (rows[i]) begin
      @(negedge clk);
      applyRow(rows[i]);  // Checked at the next rising edge
    end
    @(negedge clk);
    checkEn = 1'b0;
    @(negedge clk);
    $display("tests %0d errors %0d", testCount, errorCount);
    if (testCount != rows.size()) begin
      $display("only %0d of %0d table rows were checked", testCount, rows.size());
    end
    if ((errorCount == 0) && (testCount == rows.size())) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if ((cycleLimit != 0) && (cycleCount >= cycleLimit)) begin
      $display("timeout after %0d cycles, the table did not finish", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

endmodule

/* pipeCtrl.f */
rtl/pipeCtrlPkg.sv
rtl/instrDecoder.sv
rtl/ctrlPipe.sv
rtl/hazardUnit.sv
rtl/pipeCtrlTop.sv
bench/pipeCtrlChecker.sv
bench/pipeCtrlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the pipeline hazard control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module pipeCtrlTb \
  -f pipeCtrl.f \
  -o pipeCtrlSim

./obj_dir/pipeCtrlSim > sim.log
cat sim.log

# The testbench prints the pass line only when every row matched
if grep -qx "No errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
